// ==== rtl/core_ctrl_pkg.sv ====
`include "serial_core_config.svh"

package core_ctrl_pkg;

   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      DECODE,
      EXECUTE,
      COMMIT
   } seq_state_e;

   // Qualifiers for one serial bit step
   typedef struct packed {
      logic exec_en;
      logic first;
      logic last;
   } step_t;

   typedef struct packed {
      logic [`XLEN-1:0]   pc;
      logic [`XLEN-1:0]   next_pc;
      logic [`REG_AW-1:0] rd_addr;
      logic               rd_wen;
      logic [`XLEN-1:0]   rd_data;
   } retire_t;

endpackage

// ==== rtl/core_sequencer.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module core_sequencer (
   input  logic                 clk,
   input  logic                 i_reset,
   input  logic                 i_ibus_ack,
   output logic                 o_ibus_cyc,
   output logic                 o_decode_load,
   output core_ctrl_pkg::step_t o_step,
   output logic                 o_commit
);

   core_ctrl_pkg::seq_state_e state_q;
   core_ctrl_pkg::seq_state_e state_d;
   logic [`STEP_W-1:0]        cnt_q;
   logic                      exec;

   always_comb begin
      state_d = state_q;
      case (state_q)
         core_ctrl_pkg::IDLE: state_d = core_ctrl_pkg::FETCH;
         core_ctrl_pkg::FETCH: begin
            if (i_ibus_ack) begin
               state_d = core_ctrl_pkg::DECODE;
            end
         end
         core_ctrl_pkg::DECODE: state_d = core_ctrl_pkg::EXECUTE;
         core_ctrl_pkg::EXECUTE: begin
            if (cnt_q == '1) begin
               state_d = core_ctrl_pkg::COMMIT;
            end
         end
         core_ctrl_pkg::COMMIT: state_d = core_ctrl_pkg::FETCH;
         default: state_d = core_ctrl_pkg::IDLE;
      endcase
   end

   // Counter wraps to zero after step 31
   always_ff @(posedge clk) begin
      if (i_reset) begin
         state_q <= core_ctrl_pkg::IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (exec) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   assign exec          = (state_q == core_ctrl_pkg::EXECUTE);
   assign o_ibus_cyc    = (state_q == core_ctrl_pkg::FETCH);
   assign o_decode_load = o_ibus_cyc & i_ibus_ack;
   assign o_commit      = (state_q == core_ctrl_pkg::COMMIT);

   assign o_step = '{exec_en: exec,
                     first:   exec && (cnt_q == '0),
                     last:    exec && (cnt_q == '1)};

endmodule

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module instr_decode (
   input  logic                 clk,
   input  logic                 i_load,
   input  logic [`XLEN-1:0]     i_instr,
   output rv_isa_pkg::decoded_t o_dec,
   output logic [`XLEN-1:0]     o_imm
);

   logic [`XLEN-1:0]    instr_q;
   rv_isa_pkg::opcode_e opcode;
   logic [2:0]          funct3;
   logic [`XLEN-1:0]    imm_i;
   logic [`XLEN-1:0]    imm_u;
   logic [`XLEN-1:0]    imm_b;
   logic [`XLEN-1:0]    imm_j;

   always_ff @(posedge clk) begin
      if (i_load) begin
         instr_q <= i_instr;
      end
   end

   assign funct3 = instr_q[14:12];

   // Sign-extended immediate formats
   assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
   assign imm_u = {instr_q[31:12], 12'b0};
   assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                   instr_q[11:8], 1'b0};
   assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                   instr_q[30:21], 1'b0};

   always_comb begin
      case (instr_q[6:0])
         rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_LUI,
         rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_JAL:
            opcode = rv_isa_pkg::opcode_e'(instr_q[6:0]);
         default:
            opcode = rv_isa_pkg::OPC_UNSUP;
      endcase
   end

   always_comb begin
      o_dec        = '0;
      o_dec.rs1    = instr_q[19:15];
      o_dec.rs2    = instr_q[24:20];
      o_dec.rd     = instr_q[11:7];
      o_dec.alu_op = rv_isa_pkg::ALU_ADD;
      o_dec.rd_src = rv_isa_pkg::RD_NONE;
      o_imm        = imm_i;
      case (opcode)
         rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
            o_dec.use_imm = (opcode == rv_isa_pkg::OPC_OP_IMM);
            o_dec.rd_src  = rv_isa_pkg::RD_ALU;
            case (funct3)
               3'b000: begin
                  if (opcode == rv_isa_pkg::OPC_OP && instr_q[30]) begin
                     o_dec.alu_op = rv_isa_pkg::ALU_SUB;
                  end
               end
               3'b010: begin
                  o_dec.alu_op = rv_isa_pkg::ALU_SLT;
                  o_dec.rd_src = rv_isa_pkg::RD_CMP;
               end
               3'b011: begin
                  o_dec.alu_op = rv_isa_pkg::ALU_SLTU;
                  o_dec.rd_src = rv_isa_pkg::RD_CMP;
               end
               3'b100: o_dec.alu_op = rv_isa_pkg::ALU_XOR;
               3'b110: o_dec.alu_op = rv_isa_pkg::ALU_OR;
               3'b111: o_dec.alu_op = rv_isa_pkg::ALU_AND;
               // Shift encodings retire as no-ops
               default: o_dec.rd_src = rv_isa_pkg::RD_NONE;
            endcase
         end
         rv_isa_pkg::OPC_LUI: begin
            o_dec.rd_src = rv_isa_pkg::RD_IMM;
            o_imm        = imm_u;
         end
         rv_isa_pkg::OPC_JAL: begin
            o_dec.is_jump = 1'b1;
            o_dec.rd_src  = rv_isa_pkg::RD_LINK;
            o_imm         = imm_j;
         end
         rv_isa_pkg::OPC_BRANCH: begin
            // Only BEQ and BNE
            o_dec.alu_op       = rv_isa_pkg::ALU_SUB;
            o_dec.is_branch    = (funct3[2:1] == 2'b00);
            o_dec.branch_on_ne = funct3[0];
            o_imm              = imm_b;
         end
         default: begin
         end
      endcase
      o_dec.rd_wen = (o_dec.rd_src != rv_isa_pkg::RD_NONE) && (instr_q[11:7] != '0);
   end

endmodule

// ==== rtl/pc_unit.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module pc_unit (
   input  logic                 clk,
   input  logic                 i_reset,
   input  core_ctrl_pkg::step_t i_step,
   input  logic [`XLEN-1:0]     i_imm,
   input  logic                 i_commit,
   input  logic                 i_take_target,
   output logic [`XLEN-1:0]     o_pc,
   output logic                 o_link_bit,
   output logic [`XLEN-1:0]     o_next_pc
);

   logic [`XLEN-1:0] pc_q;
   logic [`XLEN-1:0] pc_sh_q;
   logic [`XLEN-1:0] imm_sh_q;
   logic [`XLEN-1:0] plus4_q;
   logic [`XLEN-1:0] target_q;
   logic [2:0]       four_q;
   logic             pc_bit;
   logic             imm_bit;
   logic             four_bit;
   logic             c4_q;
   logic             ct_q;
   logic [1:0]       add4;
   logic [1:0]       addt;

   // Returns carry and sum
   function automatic logic [1:0] bit_add(input logic a, input logic b, input logic c);
      return {(a & b) | (c & (a ^ b)), a ^ b ^ c};
   endfunction

   assign pc_bit   = i_step.first ? pc_q[0] : pc_sh_q[0];
   assign imm_bit  = i_step.first ? i_imm[0] : imm_sh_q[0];
   assign four_bit = ~i_step.first & four_q[0];

   assign add4 = bit_add(pc_bit, four_bit, ~i_step.first & c4_q);
   assign addt = bit_add(pc_bit, imm_bit, ~i_step.first & ct_q);

   assign o_link_bit = add4[0];
   assign o_pc       = pc_q;
   assign o_next_pc  = i_take_target ? target_q : plus4_q;

   always_ff @(posedge clk) begin
      if (i_step.exec_en) begin
         pc_sh_q  <= (i_step.first ? pc_q : pc_sh_q) >> 1;
         imm_sh_q <= (i_step.first ? i_imm : imm_sh_q) >> 1;
         // Remaining bits of the constant four after bit 0
         four_q   <= i_step.first ? 3'b010 : four_q >> 1;
         c4_q     <= add4[1];
         ct_q     <= addt[1];
         plus4_q  <= {add4[0], plus4_q[`XLEN-1:1]};
         target_q <= {addt[0], target_q[`XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc_q <= `RESET_PC;
      end else if (i_commit) begin
         pc_q <= o_next_pc;
      end
   end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module reg_file (
   input  logic                  clk,
   input  logic                  i_reset,
   input  rv_isa_pkg::reg_addr_t i_rs1_addr,
   input  rv_isa_pkg::reg_addr_t i_rs2_addr,
   output logic [`XLEN-1:0]      o_rs1,
   output logic [`XLEN-1:0]      o_rs2,
   input  logic                  i_wen,
   input  rv_isa_pkg::reg_addr_t i_waddr,
   input  logic [`XLEN-1:0]      i_wdata
);

   logic [`XLEN-1:0] regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (i_reset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wen && i_waddr != '0) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // x0 always reads zero
   assign o_rs1 = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
   assign o_rs2 = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// ==== rtl/result_commit.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module result_commit (
   input  logic                   clk,
   input  core_ctrl_pkg::step_t   i_step,
   input  logic                   i_commit,
   input  rv_isa_pkg::decoded_t   i_dec,
   input  logic [`XLEN-1:0]       i_imm,
   input  logic                   i_alu_bit,
   input  logic                   i_link_bit,
   input  logic                   i_cmp,
   input  logic [`XLEN-1:0]       i_pc,
   input  logic [`XLEN-1:0]       i_next_pc,
   output logic                   o_take_target,
   output logic                   o_wen,
   output rv_isa_pkg::reg_addr_t  o_waddr,
   output logic [`XLEN-1:0]       o_wdata,
   output logic                   o_retire,
   output core_ctrl_pkg::retire_t o_retire_rec
);

   logic [`XLEN-1:0] res_q;
   logic             res_bit;

   assign res_bit = (i_dec.rd_src == rv_isa_pkg::RD_LINK) ? i_link_bit : i_alu_bit;

   always_ff @(posedge clk) begin
      if (i_step.exec_en) begin
         res_q <= {res_bit, res_q[`XLEN-1:1]};
      end
   end

   always_comb begin
      case (i_dec.rd_src)
         rv_isa_pkg::RD_CMP:  o_wdata = {{(`XLEN-1){1'b0}}, i_cmp};
         rv_isa_pkg::RD_IMM:  o_wdata = i_imm;
         rv_isa_pkg::RD_NONE: o_wdata = '0;
         default:             o_wdata = res_q;
      endcase
   end

   // Branch flag holds equality here
   assign o_take_target = i_dec.is_jump | (i_dec.is_branch & (i_cmp ^ i_dec.branch_on_ne));

   assign o_wen    = i_commit & i_dec.rd_wen;
   assign o_waddr  = i_dec.rd;
   assign o_retire = i_commit;

   assign o_retire_rec = '{pc:      i_pc,
                           next_pc: i_next_pc,
                           rd_addr: i_dec.rd_wen ? i_dec.rd : '0,
                           rd_wen:  i_dec.rd_wen,
                           rd_data: i_dec.rd_wen ? o_wdata : '0};

endmodule

// ==== rtl/rv_isa_pkg.sv ====
`include "serial_core_config.svh"

package rv_isa_pkg;

   typedef logic [`REG_AW-1:0] reg_addr_t;

   // Major opcodes handled by the core
   typedef enum logic [6:0] {
      OPC_UNSUP  = 7'b0000000,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU
   } alu_op_e;

   // Source of the rd write value
   typedef enum logic [2:0] {
      RD_ALU,
      RD_IMM,
      RD_LINK,
      RD_CMP,
      RD_NONE
   } rd_src_e;

   typedef struct packed {
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      alu_op_e   alu_op;
      rd_src_e   rd_src;
      logic      use_imm;
      logic      is_branch;
      logic      branch_on_ne;
      logic      is_jump;
      logic      rd_wen;
   } decoded_t;

endpackage

// ==== rtl/serial_alu.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module serial_alu (
   input  logic                 clk,
   input  core_ctrl_pkg::step_t i_step,
   input  rv_isa_pkg::decoded_t i_dec,
   input  logic [`XLEN-1:0]     i_rs1,
   input  logic [`XLEN-1:0]     i_rs2,
   input  logic [`XLEN-1:0]     i_imm,
   output logic                 o_rd_bit,
   output logic                 o_cmp
);

   logic [`XLEN-1:0] op_a_q;
   logic [`XLEN-1:0] op_b_q;
   logic [`XLEN-1:0] op_b_word;
   logic             a_bit;
   logic             b_bit;
   logic             b_eff;
   logic             is_sub;
   logic             carry_in;
   logic             carry_out;
   logic             sum_bit;
   logic             lt;
   logic             carry_q;
   logic             eq_q;
   logic             cmp_q;

   assign op_b_word = i_dec.use_imm ? i_imm : i_rs2;

   // Step 0 reads the words directly
   assign a_bit = i_step.first ? i_rs1[0] : op_a_q[0];
   assign b_bit = i_step.first ? op_b_word[0] : op_b_q[0];

   assign is_sub    = i_dec.alu_op inside {rv_isa_pkg::ALU_SUB, rv_isa_pkg::ALU_SLT,
                                           rv_isa_pkg::ALU_SLTU};
   assign b_eff     = b_bit ^ is_sub;
   assign carry_in  = i_step.first ? is_sub : carry_q;
   assign sum_bit   = a_bit ^ b_eff ^ carry_in;
   assign carry_out = (a_bit & b_eff) | (carry_in & (a_bit ^ b_eff));

   // Valid on the last step where differing sign bits decide the signed case
   assign lt = (i_dec.alu_op == rv_isa_pkg::ALU_SLTU || a_bit == b_bit) ? ~carry_out : a_bit;

   always_comb begin
      case (i_dec.alu_op)
         rv_isa_pkg::ALU_AND: o_rd_bit = a_bit & b_bit;
         rv_isa_pkg::ALU_OR:  o_rd_bit = a_bit | b_bit;
         rv_isa_pkg::ALU_XOR: o_rd_bit = a_bit ^ b_bit;
         default:             o_rd_bit = sum_bit;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_step.exec_en) begin
         op_a_q  <= (i_step.first ? i_rs1 : op_a_q) >> 1;
         op_b_q  <= (i_step.first ? op_b_word : op_b_q) >> 1;
         carry_q <= carry_out;
         eq_q    <= (i_step.first | eq_q) & ~(a_bit ^ b_bit);
         if (i_step.last) begin
            cmp_q <= i_dec.is_branch ? (eq_q & ~(a_bit ^ b_bit)) : lt;
         end
      end
   end

   assign o_cmp = cmp_q;

endmodule

// ==== rtl/serial_core_config.svh ====
`ifndef SERIAL_CORE_CONFIG_SVH
`define SERIAL_CORE_CONFIG_SVH

// Data word width
`define XLEN 32

// Register file geometry
`define REG_AW 5
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000

// Counts the 32 execute steps
`define STEP_W 5

`endif

// ==== rtl/serial_core_top.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module serial_core_top (
   input  logic                   clk,
   input  logic                   i_reset,
   output logic                   o_ibus_cyc,
   output logic [`XLEN-1:0]       o_ibus_adr,
   input  logic [`XLEN-1:0]       i_ibus_rdt,
   input  logic                   i_ibus_ack,
   output logic                   o_retire,
   output core_ctrl_pkg::retire_t o_retire_rec
);

   logic                  decode_load;
   logic                  commit;
   core_ctrl_pkg::step_t  step;
   rv_isa_pkg::decoded_t  dec;
   logic [`XLEN-1:0]      imm;
   logic [`XLEN-1:0]      rs1;
   logic [`XLEN-1:0]      rs2;
   logic                  alu_bit;
   logic                  cmp;
   logic                  link_bit;
   logic [`XLEN-1:0]      next_pc;
   logic                  take_target;
   logic                  wen;
   rv_isa_pkg::reg_addr_t waddr;
   logic [`XLEN-1:0]      wdata;

   core_sequencer u_sequencer (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_ibus_ack    (i_ibus_ack),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_decode_load (decode_load),
      .o_step        (step),
      .o_commit      (commit)
   );

   instr_decode u_decode (
      .clk     (clk),
      .i_load  (decode_load),
      .i_instr (i_ibus_rdt),
      .o_dec   (dec),
      .o_imm   (imm)
   );

   reg_file u_regs (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_rs1_addr (dec.rs1),
      .i_rs2_addr (dec.rs2),
      .o_rs1      (rs1),
      .o_rs2      (rs2),
      .i_wen      (wen),
      .i_waddr    (waddr),
      .i_wdata    (wdata)
   );

   serial_alu u_alu (
      .clk      (clk),
      .i_step   (step),
      .i_dec    (dec),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_imm    (imm),
      .o_rd_bit (alu_bit),
      .o_cmp    (cmp)
   );

   pc_unit u_pc (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_step        (step),
      .i_imm         (imm),
      .i_commit      (commit),
      .i_take_target (take_target),
      .o_pc          (o_ibus_adr),
      .o_link_bit    (link_bit),
      .o_next_pc     (next_pc)
   );

   result_commit u_commit (
      .clk           (clk),
      .i_step        (step),
      .i_commit      (commit),
      .i_dec         (dec),
      .i_imm         (imm),
      .i_alu_bit     (alu_bit),
      .i_link_bit    (link_bit),
      .i_cmp         (cmp),
      .i_pc          (o_ibus_adr),
      .i_next_pc     (next_pc),
      .o_take_target (take_target),
      .o_wen         (wen),
      .o_waddr       (waddr),
      .o_wdata       (wdata),
      .o_retire      (o_retire),
      .o_retire_rec  (o_retire_rec)
   );

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/instr_decode.sv
rtl/core_sequencer.sv
rtl/serial_alu.sv
rtl/pc_unit.sv
rtl/reg_file.sv
rtl/result_commit.sv
rtl/serial_core_top.sv
testbench/tb_serial_core_asserts.sv
testbench/tb_serial_core.sv

// ==== testbench/tb_serial_core.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module tb_serial_core;

   logic                   clk;
   logic                   i_reset;
   logic                   i_ibus_ack;
   logic [`XLEN-1:0]       i_ibus_rdt;
   logic                   o_ibus_cyc;
   logic [`XLEN-1:0]       o_ibus_adr;
   logic                   o_retire;
   core_ctrl_pkg::retire_t o_retire_rec;

   logic [31:0] prog [512];
   logic [31:0] mregs [32];
   logic [31:0] rng_state = 32'd52;
   logic [31:0] test_end [$];
   string       test_name [$];
   int          plen = 0;
   int          errors = 0;
   logic        built = 1'b0;

   serial_core_top i_dut (
      .clk          (clk),
      .i_reset      (i_reset),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_ibus_adr   (o_ibus_adr),
      .i_ibus_rdt   (i_ibus_rdt),
      .i_ibus_ack   (i_ibus_ack),
      .o_retire     (o_retire),
      .o_retire_rec (o_retire_rec)
   );

   bind serial_core_top tb_serial_core_asserts u_asserts (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_cyc (o_ibus_cyc),
      .i_ibus_adr (o_ibus_adr),
      .i_ibus_ack (i_ibus_ack),
      .i_retire   (o_retire)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [4:0] pick_reg();
      logic [31:0] r;
      r = next_rand();
      return 5'(r % 31) + 5'd1;
   endfunction

   function automatic logic [4:0] other_reg(input logic [4:0] r);
      return (r == 5'd31) ? 5'd1 : r + 5'd1;
   endfunction

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, 7'h13};
   endfunction

   function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
   endfunction

   function automatic logic [31:0] jal_type(input logic [4:0] rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
   endfunction

   task automatic emit(input logic [31:0] w);
      prog[plen] = w;
      plen++;
   endtask

   // LUI/ADDI pair with the upper part rounded for the sign of the low 12 bits
   task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] hi;
      hi = v + 32'h800;
      emit({hi[31:12], rd, 7'h37});
      emit(i_type(v[11:0], rd, 3'd0, rd));
   endtask

   task automatic mark_end(input string name);
      test_name.push_back(name);
      test_end.push_back(plen * 4);
   endtask

   task automatic build_program();
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [11:0] imm;
      for (int i = 0; i < 512; i++) begin
         prog[i] = {i[24:0], 7'b0001011};
      end
      for (int k = 0; k < 20; k++) begin
         ra = pick_reg();
         rb = pick_reg();
         rd = pick_reg();
         load_reg(ra, next_rand());
         load_reg(rb, next_rand());
         a = next_rand();
         imm = a[11:0];
         case (k % 10)
            0: emit(r_type(7'h00, rb, ra, 3'd0, rd));
            1: emit(r_type(7'h20, rb, ra, 3'd0, rd));
            2: emit(r_type(7'h00, rb, ra, 3'd7, rd));
            3: emit(r_type(7'h00, rb, ra, 3'd6, rd));
            4: emit(r_type(7'h00, rb, ra, 3'd4, rd));
            5: emit(i_type(imm, ra, 3'd0, rd));
            6: emit(i_type(imm, ra, 3'd7, rd));
            7: emit(i_type(imm, ra, 3'd6, rd));
            8: emit(i_type(imm, ra, 3'd4, rd));
            default: emit({a[31:12], rd, 7'h37});
         endcase
      end
      mark_end("arith_logic");
      // Second half uses operands that differ only in bit 31
      for (int k = 0; k < 16; k++) begin
         ra = pick_reg();
         rb = other_reg(ra);
         rd = pick_reg();
         a = next_rand();
         b = next_rand();
         imm = b[11:0];
         if (k >= 8) begin
            b = a ^ 32'h8000_0000;
            if (k % 4 >= 2) begin
               a = {{20{imm[11]}}, imm} ^ 32'h8000_0000;
            end
         end
         load_reg(ra, a);
         load_reg(rb, b);
         case (k % 4)
            0: emit(r_type(7'h00, rb, ra, 3'd2, rd));
            1: emit(r_type(7'h00, rb, ra, 3'd3, rd));
            2: emit(i_type(imm, ra, 3'd2, rd));
            default: emit(i_type(imm, ra, 3'd3, rd));
         endcase
      end
      mark_end("compare");
      // Taken branches skip the filler word
      for (int k = 0; k < 8; k++) begin
         ra = pick_reg();
         rb = other_reg(ra);
         rd = pick_reg();
         a = next_rand();
         load_reg(ra, a);
         load_reg(rb, k[0] ? a ^ (32'h1 << (k * 3)) : a);
         emit(b_type(k[1] ? 3'd1 : 3'd0, ra, rb, 13'd8));
         emit(i_type(12'h321, 5'd0, 3'd0, rd));
         emit(i_type(12'h001, ra, 3'd0, rd));
      end
      for (int k = 0; k < 2; k++) begin
         rd = pick_reg();
         emit(jal_type(rd, 21'd8));
         emit(i_type(12'h7ff, 5'd0, 3'd0, rd));
         emit(r_type(7'h00, 5'd0, rd, 3'd0, other_reg(rd)));
      end
      mark_end("branch_jump");
      ra = pick_reg();
      a = next_rand();
      load_reg(ra, a);
      emit(i_type(a[11:0], ra, 3'd0, 5'd0));
      emit(r_type(7'h00, ra, ra, 3'd0, 5'd0));
      emit({a[31:12], 5'd7, 7'h03});
      emit({a[31:12], 5'd9, 7'h73});
      emit({a[31:12], 5'd11, 7'h00});
      emit(r_type(7'h00, 5'd0, 5'd0, 3'd0, ra));
      emit(i_type(12'h000, 5'd0, 3'd6, other_reg(ra)));
      mark_end("zero_and_unsupported");
   endtask

   // Expected retire record by the RV32I rules for the kept instructions
   function automatic core_ctrl_pkg::retire_t model_exec(input logic [31:0] pc,
                                                         input logic [31:0] ins);
      core_ctrl_pkg::retire_t r;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic        wr;
      a = mregs[ins[19:15]];
      b = (ins[6:0] == 7'h13) ? {{20{ins[31]}}, ins[31:20]} : mregs[ins[24:20]];
      r = '0;
      r.pc = pc;
      r.next_pc = pc + 32'd4;
      res = '0;
      wr = 1'b0;
      case (ins[6:0])
         7'h33, 7'h13: begin
            wr = 1'b1;
            case (ins[14:12])
               3'd0: res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
               3'd2: res = {31'b0, $signed(a) < $signed(b)};
               3'd3: res = {31'b0, a < b};
               3'd4: res = a ^ b;
               3'd6: res = a | b;
               3'd7: res = a & b;
               default: wr = 1'b0;
            endcase
         end
         7'h37: begin
            wr = 1'b1;
            res = {ins[31:12], 12'b0};
         end
         7'h6f: begin
            wr = 1'b1;
            res = pc + 32'd4;
            r.next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         7'h63: begin
            if ((ins[14:12] == 3'd0 && a == b) || (ins[14:12] == 3'd1 && a != b)) begin
               r.next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
         r.rd_wen = 1'b1;
         r.rd_addr = ins[11:7];
         r.rd_data = res;
      end
      return r;
   endfunction

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp, inout int test_errors);
      assert (got === exp) else begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      i_reset = 1'b1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      build_program();
      built = 1'b1;
      repeat (3) @(posedge clk);
      #1 i_reset = 1'b0;
   end

   // Fetch responder with random stray acks between fetches
   initial begin : ack_driver
      logic [31:0] rnd;
      int          delay;
      forever begin
         @(posedge clk);
         #1;
         if (o_ibus_cyc === 1'b1) begin
            rnd = next_rand();
            delay = rnd % 5;
            i_ibus_ack = 1'b0;
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            i_ibus_ack = 1'b1;
            i_ibus_rdt = prog[o_ibus_adr[10:2]];
         end else begin
            rnd = next_rand();
            i_ibus_ack = rnd[0] & rnd[1];
            i_ibus_rdt = rnd;
         end
      end
   end

   initial begin : retire_check
      core_ctrl_pkg::retire_t exp;
      logic [31:0] mpc;
      int          cur;
      int          retired;
      int          test_count;
      int          test_errors;
      mpc = `RESET_PC;
      cur = 0;
      retired = 0;
      test_count = 0;
      test_errors = 0;
      for (int i = 0; i < 32; i++) begin
         mregs[i] = '0;
      end
      wait (built);
      while (cur < test_end.size()) begin
         @(negedge clk);
         if (o_retire === 1'b1) begin
            exp = model_exec(mpc, prog[mpc[10:2]]);
            check_field("pc", o_retire_rec.pc, exp.pc, test_errors);
            check_field("next_pc", o_retire_rec.next_pc, exp.next_pc, test_errors);
            check_field("rd_addr", o_retire_rec.rd_addr, exp.rd_addr, test_errors);
            check_field("rd_wen", o_retire_rec.rd_wen, exp.rd_wen, test_errors);
            check_field("rd_data", o_retire_rec.rd_data, exp.rd_data, test_errors);
            if (exp.rd_wen) begin
               mregs[exp.rd_addr] = exp.rd_data;
            end
            mpc = exp.next_pc;
            retired++;
            test_count++;
            if (mpc == test_end[cur]) begin
               $display("%s: %0d instructions retired, %0d errors",
                        test_name[cur], test_count, test_errors);
               cur++;
               test_count = 0;
               test_errors = 0;
            end
         end
      end
      $display("Summary: %0d tests, %0d retired, %0d mismatches, %0d assertion failures",
               cur, retired, errors, i_dut.u_asserts.fail_count);
      if (errors == 0 && i_dut.u_asserts.fail_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // Twice 40 cycles of 8 ns for every program word
   initial begin : watchdog
      wait (built);
      #(plen * 640);
      $display("Timeout: the core stopped retiring before the program finished");
      $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== testbench/tb_serial_core_asserts.sv ====
`timescale 1ns/1ps
`include "serial_core_config.svh"

module tb_serial_core_asserts (
   input logic             clk,
   input logic             i_reset,
   input logic             i_ibus_cyc,
   input logic [`XLEN-1:0] i_ibus_adr,
   input logic             i_ibus_ack,
   input logic             i_retire
);

   int fail_count = 0;

   // First fetch comes right after reset at the reset vector
   a_reset_fetch: assert property (@(posedge clk)
      $fell(i_reset) |=> i_ibus_cyc && i_ibus_adr == `RESET_PC)
   else begin
      $error("first fetch missing or not at reset vector");
      fail_count++;
   end

   a_reset_quiet: assert property (@(posedge clk) i_reset |=> !i_retire)
   else begin
      $error("retire pulse during reset");
      fail_count++;
   end

   // Address holds while the ack is pending
   a_adr_stable: assert property (@(posedge clk) disable iff (i_reset)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc && $stable(i_ibus_adr))
   else begin
      $error("fetch dropped or address changed before ack");
      fail_count++;
   end

   // Decode, 32 execute steps, then commit
   a_retire_timing: assert property (@(posedge clk) disable iff (i_reset)
      i_ibus_cyc && i_ibus_ack |=>
         (!i_ibus_cyc && !i_retire) [*33] ##1 (i_retire && !i_ibus_cyc))
   else begin
      $error("retire not exactly 34 cycles after ack");
      fail_count++;
   end

   a_fetch_after_retire: assert property (@(posedge clk) disable iff (i_reset)
      i_retire |=> i_ibus_cyc && !i_retire)
   else begin
      $error("no fetch in the cycle after retire");
      fail_count++;
   end

endmodule
